// ==== rtl/sys_defs.svh ====
`ifndef SYS_DEFS_SVH
`define SYS_DEFS_SVH

//////////////////////
// Host command codes
//////////////////////

// Front panel LED override, one data word of mask and state
`define SYS_CMD_LED 8'h25

// Volume attenuation, one data word with mute and shift
`define SYS_CMD_VOL 8'h26

//////////////////////
// Data path widths
//////////////////////

`define SYS_IO_W 16
`define SYS_AUD_W 16

//////////////////////
// Key debounce
//////////////////////

// Clock cycles between two key samples
`define SYS_DEB_DIV 100000
// Equal samples needed before a button changes
`define SYS_DEB_LEN 8

`endif

// ==== rtl/sys_pkg.sv ====
`include "sys_defs.svh"

package sys_pkg;

	// LED override word, mask in the upper byte
	typedef struct packed {
		logic [7:0] mask;
		logic [7:0] state;
	} led_word_t;

	// Volume word, attenuation in the low five bits
	typedef struct packed {
		logic [10:0] rsvd;
		logic        mute;
		logic [3:0]  shift;
	} vol_word_t;

	// One host data word, read according to the latched command
	typedef union packed {
		logic [`SYS_IO_W-1:0] raw;
		led_word_t            led;
		vol_word_t            vol;
	} host_word_u;

endpackage

// ==== rtl/hps_cmd_decoder.sv ====
`timescale 1ns/1ps
`include "sys_defs.svh"

module hps_cmd_decoder
	import sys_pkg::*;
(
	input  logic       clk,
	input  logic       resetd,
	input  logic       i_io_ss,
	input  logic       i_io_clk,
	input  host_word_u i_io_din,
	output logic       o_io_ack,
	output logic [7:0] o_led_overtake,
	output logic [7:0] o_led_state,
	output logic       o_vol_mute,
	output logic [3:0] o_vol_shift
);

	logic       rack;
	logic       strobe;
	logic       has_cmd;
	logic [7:0] cmd;

	// Single cycle pulse on the strobe's rising level
	assign strobe = i_io_clk & ~rack;

	//////////////////////
	// Acknowledge pair
	//////////////////////

	// Strobe level comes back as ack two registers later
	always_ff @(posedge clk) begin
		if (resetd) begin
			rack     <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			rack     <= i_io_clk;
			o_io_ack <= rack;
		end
	end

	//////////////////////
	// Command latch
	//////////////////////

	// First word under select is the command, dropping select forgets it
	always_ff @(posedge clk) begin
		if (resetd || !i_io_ss) begin
			has_cmd <= 1'b0;
			cmd     <= '0;
		end else if (strobe && !has_cmd) begin
			has_cmd <= 1'b1;
			cmd     <= i_io_din.raw[7:0];
		end
	end

	// Data words, decoded through the view of the latched command
	always_ff @(posedge clk) begin
		if (resetd) begin
			o_led_overtake <= '0;
			o_led_state    <= '0;
			o_vol_mute     <= 1'b0;
			o_vol_shift    <= '0;
		end else if (i_io_ss && strobe && has_cmd) begin
			case (cmd)
				`SYS_CMD_LED: begin
					o_led_overtake <= i_io_din.led.mask;
					o_led_state    <= i_io_din.led.state;
				end
				`SYS_CMD_VOL: begin
					o_vol_mute  <= i_io_din.vol.mute;
					o_vol_shift <= i_io_din.vol.shift;
				end
				// Other commands belong to blocks not present here
				default: begin
				end
			endcase
		end
	end

endmodule

// ==== rtl/led_button_ctrl.sv ====
`timescale 1ns/1ps
`include "sys_defs.svh"

module led_button_ctrl
	import sys_pkg::*;
#(
	parameter int DEB_DIV = `SYS_DEB_DIV
)
(
	input  logic       clk,
	input  logic       resetd,
	input  logic       i_led_user,
	input  logic [1:0] i_led_power,
	input  logic [1:0] i_led_disk,
	input  logic [7:0] i_led_overtake,
	input  logic [7:0] i_led_state,
	input  logic [1:0] i_key,
	output logic [7:0] o_led,
	output logic       o_btn_user,
	output logic       o_btn_osd
);

	localparam int DIV_W = (DEB_DIV > 1) ? $clog2(DEB_DIV + 1) : 1;
	localparam int LEN   = `SYS_DEB_LEN;

	logic             stat_pwr;
	logic             stat_disk;
	logic [7:0]       status;
	logic [DIV_W-1:0] div;
	logic [LEN-1:0]   deb [2];
	logic [1:0]       btn;

	//////////////////////
	// LED merge
	//////////////////////

	assign stat_pwr  = i_led_power[1] & ~i_led_power[0];
	// Forced and normal disk requests both light from bit 0
	assign stat_disk = i_led_disk[0];
	assign status    = {3'b000, stat_pwr, 1'b0, stat_disk, 1'b0, i_led_user};

	assign o_led = (i_led_overtake & i_led_state) | (~i_led_overtake & status);

	//////////////////////
	// Key debounce
	//////////////////////

	// Key 1 is the user button, key 0 the OSD button
	always_ff @(posedge clk) begin
		if (resetd) begin
			div    <= '0;
			deb[0] <= '0;
			deb[1] <= '0;
			btn    <= '0;
		end else begin
			div <= (div == DIV_W'(DEB_DIV)) ? '0 : div + 1'b1;
			if (div == '0) begin
				for (int k = 0; k < 2; k++) begin
					deb[k] <= {deb[k][LEN-2:0], ~i_key[k]};
					if (&deb[k])
						btn[k] <= 1'b1;
					else if (~|deb[k])
						btn[k] <= 1'b0;
				end
			end
		end
	end

	assign o_btn_user = btn[1];
	assign o_btn_osd  = btn[0];

endmodule

// ==== rtl/audio_mixer.sv ====
`timescale 1ns/1ps
`include "sys_defs.svh"

module audio_mixer
	import sys_pkg::*;
(
	input  logic                  clk,
	input  logic                  resetd,
	input  logic                  i_signed,
	input  logic [1:0]            i_mix,
	input  logic                  i_mute,
	input  logic [3:0]            i_shift,
	input  logic [`SYS_AUD_W-1:0] i_core,
	input  logic [`SYS_AUD_W-1:0] i_pre,
	output logic [`SYS_AUD_W-1:0] o_pre,
	output logic [`SYS_AUD_W-1:0] o_out
);

	localparam int W = `SYS_AUD_W;

	logic [W-1:0]      d1;
	logic [W-1:0]      d2;
	logic [W-1:0]      smp;
	logic signed [W:0] a1;
	logic signed [W:0] a3;
	logic signed [W:0] a4;
	logic signed [W:0] pre_ext;

	assign pre_ext = $signed({i_pre[W-1], i_pre});

	always_ff @(posedge clk) begin
		if (resetd) begin
			d1    <= '0;
			d2    <= '0;
			smp   <= '0;
			a1    <= '0;
			a3    <= '0;
			a4    <= '0;
			o_pre <= '0;
			o_out <= '0;
		end else begin
			// Sample moves on only once two registers agree
			d1 <= i_core;
			d2 <= d1;
			if (d1 == d2)
				smp <= d1;

			// Unsigned input is halved to fit the signed range
			a1    <= i_signed ? $signed({smp[W-1], smp}) : $signed({2'b00, smp[W-1:1]});
			o_pre <= a1[W:1];

			case (i_mix)
				2'd0: a3 <= a1;
				2'd1: a3 <= a1 - (a1 >>> 3) + (pre_ext >>> 2);
				2'd2: a3 <= a1 - (a1 >>> 2) + (pre_ext >>> 1);
				default: a3 <= (a1 >>> 1) + pre_ext;
			endcase

			if (i_mute)
				a4 <= '0;
			else
				a4 <= a3 >>> i_shift;

			// Saturate when the two top bits disagree
			o_out <= (a4[W] ^ a4[W-1]) ? {a4[W], {(W - 1){a4[W-1]}}} : a4[W-1:0];
		end
	end

endmodule

// ==== rtl/sync_polarity_fix.sv ====
`timescale 1ns/1ps

module sync_polarity_fix (
	input  logic clk,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	localparam int CNT_W = 16;

	logic             s1;
	logic             s2;
	logic             pol;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] run_hi;
	logic [CNT_W-1:0] run_lo;

	// Longer high run means the pulse is active low
	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk) begin
		if (resetd) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			pol    <= 1'b0;
			cnt    <= '0;
			run_hi <= '0;
			run_lo <= '0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			if (s1 != s2)
				cnt <= '0;
			else if (~&cnt)
				cnt <= cnt + 1'b1;
			if (s1 & ~s2)
				run_lo <= cnt;
			if (~s1 & s2)
				run_hi <= cnt;
			pol <= run_hi > run_lo;
		end
	end

endmodule

// ==== rtl/sys_top.sv ====
`timescale 1ns/1ps
`include "sys_defs.svh"

module sys_top
	import sys_pkg::*;
#(
	parameter int DEB_DIV = `SYS_DEB_DIV
)
(
	input  logic                  clk,
	input  logic                  resetd,
	input  logic                  i_io_ss,
	input  logic                  i_io_clk,
	input  logic [`SYS_IO_W-1:0]  i_io_din,
	output logic                  o_io_ack,
	input  logic                  i_led_user,
	input  logic [1:0]            i_led_power,
	input  logic [1:0]            i_led_disk,
	input  logic [1:0]            i_key,
	output logic [7:0]            o_led,
	output logic                  o_btn_user,
	output logic                  o_btn_osd,
	input  logic                  i_hs,
	input  logic                  i_vs,
	output logic                  o_hs,
	output logic                  o_vs,
	input  logic                  i_audio_signed,
	input  logic [1:0]            i_audio_mix,
	input  logic [`SYS_AUD_W-1:0] i_audio_l,
	input  logic [`SYS_AUD_W-1:0] i_audio_r,
	output logic [`SYS_AUD_W-1:0] o_audio_l,
	output logic [`SYS_AUD_W-1:0] o_audio_r
);

	logic [7:0]            led_overtake;
	logic [7:0]            led_state;
	logic                  vol_mute;
	logic [3:0]            vol_shift;
	logic [`SYS_AUD_W-1:0] aud_l_pre;
	logic [`SYS_AUD_W-1:0] aud_r_pre;

	//////////////////////
	// Host control
	//////////////////////

	hps_cmd_decoder u_dec (
		.clk            (clk),
		.resetd         (resetd),
		.i_io_ss        (i_io_ss),
		.i_io_clk       (i_io_clk),
		.i_io_din       (host_word_u'(i_io_din)),
		.o_io_ack       (o_io_ack),
		.o_led_overtake (led_overtake),
		.o_led_state    (led_state),
		.o_vol_mute     (vol_mute),
		.o_vol_shift    (vol_shift)
	);

	led_button_ctrl #(.DEB_DIV(DEB_DIV)) u_led (
		.clk(clk), .resetd(resetd), .i_led_user(i_led_user), .i_led_power(i_led_power),
		.i_led_disk(i_led_disk), .i_led_overtake(led_overtake), .i_led_state(led_state),
		.i_key(i_key), .o_led(o_led), .o_btn_user(o_btn_user), .o_btn_osd(o_btn_osd)
	);

	//////////////////////
	// Audio and sync
	//////////////////////

	// Each channel takes the other's pre output for crossfeed
	audio_mixer mix_l (
		.clk(clk), .resetd(resetd), .i_signed(i_audio_signed), .i_mix(i_audio_mix),
		.i_mute(vol_mute), .i_shift(vol_shift), .i_core(i_audio_l), .i_pre(aud_r_pre),
		.o_pre(aud_l_pre), .o_out(o_audio_l)
	);

	audio_mixer mix_r (
		.clk(clk), .resetd(resetd), .i_signed(i_audio_signed), .i_mix(i_audio_mix),
		.i_mute(vol_mute), .i_shift(vol_shift), .i_core(i_audio_r), .i_pre(aud_l_pre),
		.o_pre(aud_r_pre), .o_out(o_audio_r)
	);

	sync_polarity_fix hs_fix (.clk(clk), .resetd(resetd), .i_sync(i_hs), .o_sync(o_hs));
	sync_polarity_fix vs_fix (.clk(clk), .resetd(resetd), .i_sync(i_vs), .o_sync(o_vs));

endmodule

// ==== sim/sys_top_checker.sv ====
`timescale 1ns/1ps

module sys_top_checker (
	input logic        clk,
	input logic        resetd,
	input logic        i_io_clk,
	input logic        o_io_ack,
	input logic        vol_mute,
	input logic [15:0] o_audio_l,
	input logic [15:0] o_audio_r
);

	// Ack is the strobe level two registers later
	ack_follows_strobe: assert property (@(posedge clk) disable iff (resetd)
		$rose(o_io_ack) |-> $past(i_io_clk, 2))
		else $error("o_io_ack rose without i_io_clk high two cycles before");

	ack_low_after_reset: assert property (@(posedge clk) resetd |=> !o_io_ack)
		else $error("o_io_ack high in the cycle after reset");

	mute_silences: assert property (@(posedge clk) disable iff (resetd)
		vol_mute [*8] |-> (o_audio_l == '0 && o_audio_r == '0))
		else $error("audio output not zero while muted");

endmodule

bind sys_top sys_top_checker u_checker (.*);

// ==== sim/sys_top_tb.sv ====
`timescale 1ns/1ps
`include "sys_defs.svh"

module sys_top_tb;

	localparam int K_LED = 0;
	localparam int K_AUD_L = 1;
	localparam int K_AUD_R = 2;
	localparam int K_HS = 3;
	localparam int K_VS = 4;
	localparam int K_BTN_USER = 5;
	localparam int K_BTN_OSD = 6;
	localparam int K_ACK = 7;

	logic                  clk, resetd, i_io_ss, i_io_clk, o_io_ack;
	logic [`SYS_IO_W-1:0]  i_io_din;
	logic                  i_led_user, o_btn_user, o_btn_osd;
	logic [1:0]            i_led_power, i_led_disk, i_key, i_audio_mix;
	logic [7:0]            o_led;
	logic                  i_hs, i_vs, o_hs, o_vs, i_audio_signed;
	logic [`SYS_AUD_W-1:0] i_audio_l, i_audio_r, o_audio_l, o_audio_r;

	int unsigned seed = 97;
	int          errors = 0;
	int          checks = 0;
	int          test_errs = 0;
	logic [7:0]  ovr_mask, ovr_state;
	logic        mute_m;
	logic [3:0]  shift_m;
	int          kind_q[$];
	logic [15:0] exp_q[$];
	event        check_ev;
	string       sig_name [8] = '{"o_led", "o_audio_l", "o_audio_r", "o_hs", "o_vs",
		"o_btn_user", "o_btn_osd", "o_io_ack"};

	sys_top #(.DEB_DIV(3)) DUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////
	// Models
	//////////////////////

	function automatic logic [15:0] rand16();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:16];
	endfunction

	function automatic logic [7:0] expected_led(input logic user, input logic [1:0] pwr,
		input logic [1:0] disk, input logic [7:0] mask, input logic [7:0] state);
		logic [7:0] st;
		st = 8'h00;
		st[4] = (pwr == 2'b10);
		st[2] = disk[0];
		st[0] = user;
		return (mask & state) | (~mask & st);
	endfunction

	// Own sample mixed with the other channel's halved value
	function automatic logic [15:0] expected_mix(input logic [15:0] own, input logic [15:0] oth,
		input logic [1:0] mode, input logic sgn, input logic mute, input logic [3:0] sh);
		int a;
		int b;
		int m;
		if (sgn) begin
			a = $signed(own);
			b = $signed(oth);
		end else begin
			a = own >> 1;
			b = oth >> 1;
		end
		b = b >>> 1;
		case (mode)
			2'd0: m = a;
			2'd1: m = a - (a >>> 3) + (b >>> 2);
			2'd2: m = a - (a >>> 2) + (b >>> 1);
			default: m = (a >>> 1) + b;
		endcase
		m = mute ? 0 : (m >>> sh);
		if (m > 32767)
			m = 32767;
		if (m < -32768)
			m = -32768;
		return m[15:0];
	endfunction

	// High during the pulse once polarity is settled
	function automatic logic expected_sync(input int c, input int period, input int width);
		return (c % period) < width;
	endfunction

	function automatic logic [15:0] probe(input int kind);
		case (kind)
			K_LED: return {8'h00, o_led};
			K_AUD_L: return o_audio_l;
			K_AUD_R: return o_audio_r;
			K_HS: return {15'd0, o_hs};
			K_VS: return {15'd0, o_vs};
			K_BTN_USER: return {15'd0, o_btn_user};
			K_BTN_OSD: return {15'd0, o_btn_osd};
			default: return {15'd0, o_io_ack};
		endcase
	endfunction

	//////////////////////
	// Helpers
	//////////////////////

	task automatic timeout_abort(input string what);
		$display("Timeout at %0t: %s", $time, what);
		$display(">>> FAIL");
		$finish;
	endtask

	task automatic expect_val(input int kind, input logic [15:0] value);
		kind_q.push_back(kind);
		exp_q.push_back(value);
		-> check_ev;
	endtask

	task automatic end_test(input string name);
		@(posedge clk);
		$display("test %s %s", name, (test_errs == 0) ? "ok" : "failed");
		test_errs = 0;
	endtask

	task automatic wait_level(input int kind, input logic [15:0] v, input int limit,
		input string what);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > limit)
				timeout_abort(what);
		end while (probe(kind) !== v);
	endtask

	task automatic send_word(input logic [15:0] w);
		@(posedge clk);
		i_io_din <= w;
		i_io_clk <= 1'b1;
		wait_level(K_ACK, 16'd1, 10, "o_io_ack did not rise");
		@(posedge clk);
		i_io_clk <= 1'b0;
		wait_level(K_ACK, 16'd0, 10, "o_io_ack did not fall");
	endtask

	task automatic check_led();
		@(negedge clk);
		expect_val(K_LED, expected_led(i_led_user, i_led_power, i_led_disk, ovr_mask, ovr_state));
	endtask

	// Crossfeed needs both channels held before the outputs settle
	task automatic apply_audio(input logic [15:0] l, input logic [15:0] r,
		input logic [1:0] m, input logic s);
		@(posedge clk);
		i_audio_l <= l;
		i_audio_r <= r;
		i_audio_mix <= m;
		i_audio_signed <= s;
		repeat (16) @(posedge clk);
		@(negedge clk);
		expect_val(K_AUD_L, expected_mix(l, r, m, s, mute_m, shift_m));
		expect_val(K_AUD_R, expected_mix(r, l, m, s, mute_m, shift_m));
	endtask

	always begin : compare_proc
		int          kind;
		logic [15:0] e;
		logic [15:0] act;
		@(check_ev);
		while (kind_q.size() > 0) begin
			kind = kind_q.pop_front();
			e = exp_q.pop_front();
			act = probe(kind);
			checks++;
			if (act !== e) begin
				$display("CHECK FAILED t=%0t %s expected %h actual %h", $time,
					sig_name[kind], e, act);
				errors++;
				test_errs++;
			end
		end
	end

	//////////////////////
	// Stimulus
	//////////////////////

	initial begin
		logic [15:0] w;
		logic [15:0] x;
		resetd = 1'b1;
		{i_io_ss, i_io_clk, i_io_din} = '0;
		{i_led_user, i_led_power, i_led_disk} = '0;
		i_key = 2'b11;
		{i_hs, i_vs} = 2'b11;
		{i_audio_signed, i_audio_mix, i_audio_l, i_audio_r} = '0;
		{ovr_mask, ovr_state, mute_m, shift_m} = '0;
		repeat (10) @(posedge clk);
		resetd <= 1'b0;

		w = rand16();
		@(posedge clk);
		{i_led_user, i_led_power, i_led_disk} <= w[4:0];
		@(negedge clk);
		expect_val(K_ACK, 16'd0);
		check_led();
		end_test("reset");

		@(posedge clk);
		i_io_ss <= 1'b1;
		send_word(`SYS_CMD_LED);
		repeat (4) begin
			w = rand16();
			x = rand16();
			@(posedge clk);
			{i_led_user, i_led_power, i_led_disk} <= x[4:0];
			send_word(w);
			ovr_mask = w[15:8];
			ovr_state = w[7:0];
			check_led();
		end
		@(posedge clk);
		i_io_ss <= 1'b0;
		// Without select nothing is latched
		send_word(rand16());
		check_led();
		@(posedge clk);
		i_io_ss <= 1'b1;
		send_word(16'h002A);
		send_word(rand16());
		@(posedge clk);
		i_io_ss <= 1'b0;
		check_led();
		end_test("led");

		for (int m = 0; m < 4; m++) begin
			for (int s = 0; s < 2; s++) begin
				apply_audio(16'h7FFF, 16'h8000, m[1:0], s[0]);
				apply_audio(16'h8000, 16'h7FFF, m[1:0], s[0]);
				w = rand16();
				x = rand16();
				apply_audio(w, x, m[1:0], s[0]);
			end
		end
		end_test("mixer");

		@(posedge clk);
		i_io_ss <= 1'b1;
		send_word(`SYS_CMD_VOL);
		repeat (4) begin
			w = rand16();
			x = rand16();
			send_word({12'h000, w[3:0]});
			shift_m = w[3:0];
			apply_audio(x, rand16(), w[9:8], w[12]);
		end
		send_word(16'h0010);
		mute_m = 1'b1;
		apply_audio(16'h7FFF, 16'h8000, 2'd0, 1'b1);
		send_word(16'h0000);
		{mute_m, shift_m} = '0;
		@(posedge clk);
		i_io_ss <= 1'b0;
		end_test("volume");

		// Key 1 is the user button
		@(posedge clk);
		i_key <= 2'b01;
		wait_level(K_BTN_USER, 16'd1, 100, "o_btn_user did not set");
		expect_val(K_BTN_OSD, 16'd0);
		@(posedge clk);
		i_key <= 2'b11;
		wait_level(K_BTN_USER, 16'd0, 100, "o_btn_user did not clear");
		@(posedge clk);
		i_key <= 2'b10;
		wait_level(K_BTN_OSD, 16'd1, 100, "o_btn_osd did not set");
		expect_val(K_BTN_USER, 16'd0);
		@(posedge clk);
		i_key <= 2'b11;
		wait_level(K_BTN_OSD, 16'd0, 100, "o_btn_osd did not clear");
		// Low for one sample period only, far short of a full window
		@(posedge clk);
		i_key <= 2'b10;
		for (int n = 0; n < 48; n++) begin
			@(posedge clk);
			if (n == 3)
				i_key <= 2'b11;
			@(negedge clk);
			expect_val(K_BTN_OSD, 16'd0);
		end
		expect_val(K_BTN_USER, 16'd0);
		end_test("debounce");

		for (int c = 0; c < 360; c++) begin
			@(posedge clk);
			i_hs <= ~expected_sync(c, 40, 4);
			i_vs <= ~expected_sync(c, 60, 6);
			if (c >= 120) begin
				@(negedge clk);
				expect_val(K_HS, {15'd0, expected_sync(c, 40, 4)});
				expect_val(K_VS, {15'd0, expected_sync(c, 60, 6)});
			end
		end
		end_test("sync");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/sys_pkg.sv
rtl/hps_cmd_decoder.sv
rtl/led_button_ctrl.sv
rtl/audio_mixer.sv
rtl/sync_polarity_fix.sv
rtl/sys_top.sv
sim/sys_top_checker.sv
sim/sys_top_tb.sv

// ==== Bender.yml ====
package:
  name: sys_top

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/sys_pkg.sv
      - rtl/hps_cmd_decoder.sv
      - rtl/led_button_ctrl.sv
      - rtl/audio_mixer.sv
      - rtl/sync_polarity_fix.sv
      - rtl/sys_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - sim/sys_top_checker.sv
      - sim/sys_top_tb.sv
